// ==== source/decodeSettings.svh ====
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

`define XLEN 32
`define REG_ADDR_WIDTH 5
`define OPCODE_WIDTH 7

// Extra cycles allowed beyond the trace length
`define TIMEOUT_MARGIN 16

`endif

// ==== source/decodePkg.sv ====
`include "decodeSettings.svh"

package decodePkg;

    typedef enum logic [`OPCODE_WIDTH-1:0] {
        opLoad    = 7'h03,
        opMiscMem = 7'h0F,
        opAluImm  = 7'h13,
        opAuipc   = 7'h17,
        opStore   = 7'h23,
        opAluReg  = 7'h33,
        opLui     = 7'h37,
        opBranch  = 7'h63,
        opJalr    = 7'h67,
        opJal     = 7'h6F,
        opSystem  = 7'h73
    } opcodeValue;

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSll  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluSlt  = 4'd8,
        aluSltu = 4'd9
    } aluOp;

    typedef enum logic [1:0] {
        srcRs1Rs2  = 2'd0,
        srcRs1Imm  = 2'd1,
        srcPcImm   = 2'd2,
        srcZeroImm = 2'd3
    } aluSourceSel;

    typedef enum logic [1:0] {
        wbNone    = 2'd0,
        wbAlu     = 2'd1,
        wbMemory  = 2'd2,
        wbPcPlus4 = 2'd3
    } writebackSel;

    typedef enum logic [2:0] {
        branchNone = 3'd0,
        branchEq   = 3'd1,
        branchNe   = 3'd2,
        branchLt   = 3'd3,
        branchGe   = 3'd4,
        branchLtu  = 3'd5,
        branchGeu  = 3'd6
    } branchCond;

    typedef enum logic [1:0] {
        jumpNone = 2'd0,
        jumpJal  = 2'd1,
        jumpJalr = 2'd2
    } jumpKind;

    typedef enum logic [2:0] {
        immNone = 3'd0,
        immI    = 3'd1,
        immS    = 3'd2,
        immB    = 3'd3,
        immU    = 3'd4,
        immJ    = 3'd5
    } immFormat;

    // Five causes need three bits
    typedef enum logic [2:0] {
        trapNone        = 3'd0,
        trapIllegal     = 3'd1,
        trapEcall       = 3'd2,
        trapEbreak      = 3'd3,
        trapAccessFault = 3'd4
    } trapCause;

    typedef enum logic [1:0] {
        memByte = 2'b00,
        memHalf = 2'b01,
        memWord = 2'b11
    } memWidth;

    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`OPCODE_WIDTH-1:0]   opcode;
    } rFormatFields;

    typedef struct packed {
        logic [11:0]                immediate;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`OPCODE_WIDTH-1:0]   opcode;
    } iFormatFields;

    typedef struct packed {
        logic [6:0]                 immediateHigh;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [4:0]                 immediateLow;
        logic [`OPCODE_WIDTH-1:0]   opcode;
    } sFormatFields;

    // Immediate slices shared by the B, U and J layouts
    typedef struct packed {
        logic                     signBit;
        logic [5:0]               bits30To25;
        logic [3:0]               bits24To21;
        logic                     bit20;
        logic [7:0]               bits19To12;
        logic [3:0]               bits11To8;
        logic                     bit7;
        logic [`OPCODE_WIDTH-1:0] opcode;
    } bujFormatFields;

    typedef union packed {
        rFormatFields   rType;
        iFormatFields   iType;
        sFormatFields   sType;
        bujFormatFields bujType;
    } instructionWord;

endpackage

// ==== source/instructionDecoder.sv ====
`include "decodeSettings.svh"

module instructionDecoder (
    input  decodePkg::instructionWord     instruction,
    input  logic                          fetchAccessFault,
    input  logic [`XLEN-1:0]              programCounter,
    output logic [`REG_ADDR_WIDTH-1:0]    readAddress1,
    output logic [`REG_ADDR_WIDTH-1:0]    readAddress2,
    output logic [`REG_ADDR_WIDTH-1:0]    destinationRegister,
    output decodePkg::aluOp               aluOperation,
    output decodePkg::aluSourceSel        aluSource,
    output decodePkg::writebackSel        writeback,
    output decodePkg::branchCond          branch,
    output decodePkg::jumpKind            jump,
    output decodePkg::immFormat           format,
    output logic                          memoryRead,
    output logic                          memoryWrite,
    output logic                          memorySigned,
    output decodePkg::memWidth            memoryWidth,
    output decodePkg::trapCause           trap,
    output logic [`XLEN-1:0]              faultingAddress
);

    decodePkg::opcodeValue opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = decodePkg::opcodeValue'(instruction.rType.opcode);
    assign funct3 = instruction.rType.funct3;
    assign funct7 = instruction.rType.funct7;

    always_comb begin
        readAddress1 = '0;
        readAddress2 = '0;
        destinationRegister = '0;
        aluOperation = decodePkg::aluAdd;
        aluSource = decodePkg::srcRs1Rs2;
        writeback = decodePkg::wbNone;
        branch = decodePkg::branchNone;
        jump = decodePkg::jumpNone;
        format = decodePkg::immNone;
        memoryRead = 1'b0;
        memoryWrite = 1'b0;
        memorySigned = 1'b0;
        memoryWidth = decodePkg::memByte;
        trap = decodePkg::trapNone;
        faultingAddress = '0;
        case (opcode)
            decodePkg::opAluReg: begin
                destinationRegister = instruction.rType.rd;
                readAddress1 = instruction.rType.rs1;
                readAddress2 = instruction.rType.rs2;
                writeback = decodePkg::wbAlu;
                case ({funct7, funct3})
                    10'b0000000_000: aluOperation = decodePkg::aluAdd;
                    10'b0100000_000: aluOperation = decodePkg::aluSub;
                    10'b0000000_111: aluOperation = decodePkg::aluAnd;
                    10'b0000000_110: aluOperation = decodePkg::aluOr;
                    10'b0000000_100: aluOperation = decodePkg::aluXor;
                    10'b0000000_001: aluOperation = decodePkg::aluSll;
                    10'b0000000_101: aluOperation = decodePkg::aluSrl;
                    10'b0100000_101: aluOperation = decodePkg::aluSra;
                    10'b0000000_010: aluOperation = decodePkg::aluSlt;
                    10'b0000000_011: aluOperation = decodePkg::aluSltu;
                    default: trap = decodePkg::trapIllegal;
                endcase
            end
            decodePkg::opAluImm: begin
                destinationRegister = instruction.rType.rd;
                readAddress1 = instruction.rType.rs1;
                aluSource = decodePkg::srcRs1Imm;
                writeback = decodePkg::wbAlu;
                format = decodePkg::immI;
                case (funct3)
                    3'b000: aluOperation = decodePkg::aluAdd;
                    3'b010: aluOperation = decodePkg::aluSlt;
                    3'b011: aluOperation = decodePkg::aluSltu;
                    3'b100: aluOperation = decodePkg::aluXor;
                    3'b110: aluOperation = decodePkg::aluOr;
                    3'b111: aluOperation = decodePkg::aluAnd;
                    3'b001: begin
                        aluOperation = decodePkg::aluSll;
                        if (funct7 != 7'b0000000)
                            trap = decodePkg::trapIllegal;
                    end
                    default: begin // SRLI or SRAI
                        if (funct7 == 7'b0000000)
                            aluOperation = decodePkg::aluSrl;
                        else if (funct7 == 7'b0100000)
                            aluOperation = decodePkg::aluSra;
                        else
                            trap = decodePkg::trapIllegal;
                    end
                endcase
            end
            decodePkg::opLoad: begin
                destinationRegister = instruction.rType.rd;
                readAddress1 = instruction.rType.rs1;
                aluSource = decodePkg::srcRs1Imm;
                writeback = decodePkg::wbMemory;
                format = decodePkg::immI;
                memoryRead = 1'b1;
                memorySigned = !funct3[2]; // LBU and LHU zero-extend
                case (funct3)
                    3'b000, 3'b100: memoryWidth = decodePkg::memByte;
                    3'b001, 3'b101: memoryWidth = decodePkg::memHalf;
                    3'b010: memoryWidth = decodePkg::memWord;
                    default: trap = decodePkg::trapIllegal;
                endcase
            end
            decodePkg::opStore: begin
                readAddress1 = instruction.rType.rs1;
                readAddress2 = instruction.rType.rs2;
                aluSource = decodePkg::srcRs1Imm;
                format = decodePkg::immS;
                memoryWrite = 1'b1;
                case (funct3)
                    3'b000: memoryWidth = decodePkg::memByte;
                    3'b001: memoryWidth = decodePkg::memHalf;
                    3'b010: memoryWidth = decodePkg::memWord;
                    default: trap = decodePkg::trapIllegal;
                endcase
            end
            decodePkg::opBranch: begin
                readAddress1 = instruction.rType.rs1;
                readAddress2 = instruction.rType.rs2;
                aluSource = decodePkg::srcPcImm;
                format = decodePkg::immB;
                case (funct3)
                    3'b000: branch = decodePkg::branchEq;
                    3'b001: branch = decodePkg::branchNe;
                    3'b100: branch = decodePkg::branchLt;
                    3'b101: branch = decodePkg::branchGe;
                    3'b110: branch = decodePkg::branchLtu;
                    3'b111: branch = decodePkg::branchGeu;
                    default: trap = decodePkg::trapIllegal;
                endcase
            end
            decodePkg::opLui, decodePkg::opAuipc: begin
                destinationRegister = instruction.rType.rd;
                writeback = decodePkg::wbAlu;
                format = decodePkg::immU;
                if (opcode == decodePkg::opLui)
                    aluSource = decodePkg::srcZeroImm;
                else
                    aluSource = decodePkg::srcPcImm;
            end
            decodePkg::opJal: begin
                destinationRegister = instruction.rType.rd;
                aluSource = decodePkg::srcPcImm;
                writeback = decodePkg::wbPcPlus4;
                jump = decodePkg::jumpJal;
                format = decodePkg::immJ;
            end
            decodePkg::opJalr: begin
                destinationRegister = instruction.rType.rd;
                readAddress1 = instruction.rType.rs1;
                aluSource = decodePkg::srcRs1Imm;
                writeback = decodePkg::wbPcPlus4;
                jump = decodePkg::jumpJalr;
                format = decodePkg::immI;
                if (funct3 != 3'b000)
                    trap = decodePkg::trapIllegal;
            end
            decodePkg::opMiscMem: begin
                if (funct3[2:1] != 2'b00) // FENCE and FENCE.I only
                    trap = decodePkg::trapIllegal;
            end
            decodePkg::opSystem: begin
                destinationRegister = instruction.rType.rd;
                readAddress1 = instruction.rType.rs1;
                case (instruction)
                    32'h00000073: trap = decodePkg::trapEcall;
                    32'h00100073: trap = decodePkg::trapEbreak;
                    32'h10500073: ; // WFI
                    default: trap = decodePkg::trapIllegal; // CSR access and MRET
                endcase
            end
            default: trap = decodePkg::trapIllegal;
        endcase
        if (trap == decodePkg::trapIllegal) begin
            format = decodePkg::immNone;
            faultingAddress = instruction;
        end
        if (fetchAccessFault) begin // Fetch fault outranks decode
            trap = decodePkg::trapAccessFault;
            faultingAddress = programCounter;
        end
    end

endmodule

// ==== source/immediateGenerator.sv ====
`include "decodeSettings.svh"

module immediateGenerator (
    input  decodePkg::instructionWord instruction,
    input  decodePkg::immFormat       format,
    output logic [`XLEN-1:0]          immediate
);

    logic sign;

    assign sign = instruction.bujType.signBit; // Bit 31 in every format

    always_comb begin
        case (format)
            decodePkg::immI: immediate = {{(`XLEN-12){sign}}, instruction.iType.immediate};
            decodePkg::immS: immediate = {{(`XLEN-12){sign}},
                                          instruction.sType.immediateHigh,
                                          instruction.sType.immediateLow};
            decodePkg::immB: immediate = {{(`XLEN-12){sign}},
                                          instruction.bujType.bit7,
                                          instruction.bujType.bits30To25,
                                          instruction.bujType.bits11To8,
                                          1'b0};
            decodePkg::immU: immediate = {sign,
                                          instruction.bujType.bits30To25,
                                          instruction.bujType.bits24To21,
                                          instruction.bujType.bit20,
                                          instruction.bujType.bits19To12,
                                          12'd0};
            decodePkg::immJ: immediate = {{(`XLEN-20){sign}},
                                          instruction.bujType.bits19To12,
                                          instruction.bujType.bit20,
                                          instruction.bujType.bits30To25,
                                          instruction.bujType.bits24To21,
                                          1'b0};
            default: immediate = '0;
        endcase
    end

endmodule

// ==== source/decodeExecuteRegister.sv ====
`include "decodeSettings.svh"

module decodeExecuteRegister (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          flush,
    input  logic                          fetchValid,
    input  logic [`XLEN-1:0]              programCounter,
    input  logic [`REG_ADDR_WIDTH-1:0]    destinationRegister,
    input  decodePkg::aluOp               aluOperation,
    input  decodePkg::aluSourceSel        aluSource,
    input  decodePkg::writebackSel        writeback,
    input  decodePkg::branchCond          branch,
    input  decodePkg::jumpKind            jump,
    input  decodePkg::immFormat           format,
    input  logic                          memoryRead,
    input  logic                          memoryWrite,
    input  logic                          memorySigned,
    input  decodePkg::memWidth            memoryWidth,
    input  decodePkg::trapCause           trap,
    input  logic [`XLEN-1:0]              faultingAddress,
    input  logic [`XLEN-1:0]              immediate,
    output logic                          executeValid,
    output logic [`XLEN-1:0]              executeProgramCounter,
    output logic [`REG_ADDR_WIDTH-1:0]    executeDestinationRegister,
    output decodePkg::aluOp               executeAluOperation,
    output decodePkg::aluSourceSel        executeAluSource,
    output decodePkg::writebackSel        executeWriteback,
    output decodePkg::branchCond          executeBranch,
    output decodePkg::jumpKind            executeJump,
    output decodePkg::immFormat           executeFormat,
    output logic                          executeMemoryRead,
    output logic                          executeMemoryWrite,
    output logic                          executeMemorySigned,
    output decodePkg::memWidth            executeMemoryWidth,
    output decodePkg::trapCause           executeTrap,
    output logic [`XLEN-1:0]              executeFaultingAddress,
    output logic [`XLEN-1:0]              executeImmediate
);

    logic squash;

    assign squash = fetchValid && trap != decodePkg::trapNone;

    always_ff @(posedge clock) begin
        if (reset) begin
            executeValid <= 1'b0;
            executeProgramCounter <= '0;
            executeDestinationRegister <= '0;
            executeAluOperation <= decodePkg::aluAdd;
            executeAluSource <= decodePkg::srcRs1Rs2;
            executeWriteback <= decodePkg::wbNone;
            executeBranch <= decodePkg::branchNone;
            executeJump <= decodePkg::jumpNone;
            executeFormat <= decodePkg::immNone;
            executeMemoryRead <= 1'b0;
            executeMemoryWrite <= 1'b0;
            executeMemorySigned <= 1'b0;
            executeMemoryWidth <= decodePkg::memByte;
            executeTrap <= decodePkg::trapNone;
            executeFaultingAddress <= '0;
            executeImmediate <= '0;
        end else if (flush) begin
            executeValid <= 1'b0; // Payload left as is
        end else if (!stall) begin
            executeValid <= fetchValid;
            executeProgramCounter <= programCounter;
            executeDestinationRegister <= squash ? '0 : destinationRegister;
            executeAluOperation <= aluOperation;
            executeAluSource <= aluSource;
            executeWriteback <= squash ? decodePkg::wbNone : writeback;
            executeBranch <= branch;
            executeJump <= jump;
            executeFormat <= format;
            executeMemoryRead <= memoryRead && !squash;
            executeMemoryWrite <= memoryWrite && !squash;
            executeMemorySigned <= memorySigned;
            executeMemoryWidth <= memoryWidth;
            executeTrap <= trap;
            executeFaultingAddress <= faultingAddress;
            executeImmediate <= immediate;
        end
    end

    flushClearsValid: assert property (@(posedge clock) disable iff (reset)
        flush |=> !executeValid);

    trapBlocksMemory: assert property (@(posedge clock) disable iff (reset)
        executeValid && executeTrap != decodePkg::trapNone
            |-> !executeMemoryRead && !executeMemoryWrite);

    stallHoldsOutputs: assert property (@(posedge clock) disable iff (reset)
        stall && !flush |=> $stable({executeValid, executeProgramCounter,
            executeDestinationRegister, executeAluOperation, executeAluSource,
            executeWriteback, executeBranch, executeJump, executeFormat,
            executeMemoryRead, executeMemoryWrite, executeMemorySigned,
            executeMemoryWidth, executeTrap, executeFaultingAddress,
            executeImmediate}));

endmodule

// ==== source/decodeStage.sv ====
`include "decodeSettings.svh"

module decodeStage (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          fetchValid,
    input  logic                          fetchAccessFault,
    input  decodePkg::instructionWord     instruction,
    input  logic [`XLEN-1:0]              programCounter,
    input  logic                          stall,
    input  logic                          flush,
    output logic [`REG_ADDR_WIDTH-1:0]    readAddress1,
    output logic [`REG_ADDR_WIDTH-1:0]    readAddress2,
    output logic                          executeValid,
    output logic [`XLEN-1:0]              executeProgramCounter,
    output logic [`REG_ADDR_WIDTH-1:0]    executeDestinationRegister,
    output decodePkg::aluOp               executeAluOperation,
    output decodePkg::aluSourceSel        executeAluSource,
    output decodePkg::writebackSel        executeWriteback,
    output decodePkg::branchCond          executeBranch,
    output decodePkg::jumpKind            executeJump,
    output decodePkg::immFormat           executeFormat,
    output logic                          executeMemoryRead,
    output logic                          executeMemoryWrite,
    output logic                          executeMemorySigned,
    output decodePkg::memWidth            executeMemoryWidth,
    output decodePkg::trapCause           executeTrap,
    output logic [`XLEN-1:0]              executeFaultingAddress,
    output logic [`XLEN-1:0]              executeImmediate
);

    logic [`REG_ADDR_WIDTH-1:0] destinationRegister;
    decodePkg::aluOp            aluOperation;
    decodePkg::aluSourceSel     aluSource;
    decodePkg::writebackSel     writeback;
    decodePkg::branchCond       branch;
    decodePkg::jumpKind         jump;
    decodePkg::immFormat        format;
    logic                       memoryRead;
    logic                       memoryWrite;
    logic                       memorySigned;
    decodePkg::memWidth         memoryWidth;
    decodePkg::trapCause        trap;
    logic [`XLEN-1:0]           faultingAddress;
    logic [`XLEN-1:0]           immediate;

    // Ports and wires share names throughout
    instructionDecoder u_decoder (.*);

    immediateGenerator u_immediate (.*);

    decodeExecuteRegister u_register (.*);

endmodule

// ==== tests/decodeChecker.sv ====
`include "decodeSettings.svh"

module decodeChecker (
    input  logic                       clock,
    input  logic                       traceDone,
    input  logic [31:0]                expectedFields [19],
    input  logic [`REG_ADDR_WIDTH-1:0] readAddress1,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddress2,
    input  logic                       executeValid,
    input  logic [`XLEN-1:0]           executeProgramCounter,
    input  logic [`REG_ADDR_WIDTH-1:0] executeDestinationRegister,
    input  logic [3:0]                 executeAluOperation,
    input  logic [1:0]                 executeAluSource,
    input  logic [1:0]                 executeWriteback,
    input  logic [2:0]                 executeBranch,
    input  logic [1:0]                 executeJump,
    input  logic [2:0]                 executeFormat,
    input  logic                       executeMemoryRead,
    input  logic                       executeMemoryWrite,
    input  logic                       executeMemorySigned,
    input  logic [1:0]                 executeMemoryWidth,
    input  logic [2:0]                 executeTrap,
    input  logic [`XLEN-1:0]           executeFaultingAddress,
    input  logic [`XLEN-1:0]           executeImmediate,
    output int                         errorCount
);

    logic [31:0] pending [19]; // Line whose registered outputs are due
    logic pendingValid = 1'b0;
    logic [31:0] currentTest = '0;
    int errors = 0;
    int testErrors = 0;
    int testsRun = 0;
    int failedTests = 0;

    assign errorCount = errors;

    task automatic compareField(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, got %h (test %0d)", name, expected, actual,
                     currentTest);
            errors++;
            testErrors++;
        end
    endtask

    task automatic reportTest();
        testsRun++;
        if (testErrors == 0) begin
            $display("Test %0d passed", currentTest);
        end else begin
            $display("Test %0d failed with %0d errors", currentTest, testErrors);
            failedTests++;
        end
        testErrors = 0;
    endtask

    always @(posedge clock or negedge clock or posedge traceDone) begin
        int index;
        if (traceDone) begin
            if (currentTest != 0)
                reportTest();
            $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, failedTests,
                     errors);
        end else if (clock) begin
            pendingValid = 1'b0;
            if (expectedFields[0] != 0) begin
                if (expectedFields[0] != currentTest) begin
                    if (currentTest != 0)
                        reportTest();
                    currentTest = expectedFields[0];
                end
                compareField("readAddress1", expectedFields[1], 32'(readAddress1));
                compareField("readAddress2", expectedFields[2], 32'(readAddress2));
                for (index = 0; index < 19; index++)
                    pending[index] = expectedFields[index];
                pendingValid = 1'b1;
            end
        end else if (pendingValid) begin
            compareField("executeValid", pending[3], 32'(executeValid));
            compareField("executeProgramCounter", pending[4], 32'(executeProgramCounter));
            compareField("executeDestinationRegister", pending[5],
                         32'(executeDestinationRegister));
            compareField("executeAluOperation", pending[6], 32'(executeAluOperation));
            compareField("executeAluSource", pending[7], 32'(executeAluSource));
            compareField("executeWriteback", pending[8], 32'(executeWriteback));
            compareField("executeBranch", pending[9], 32'(executeBranch));
            compareField("executeJump", pending[10], 32'(executeJump));
            compareField("executeFormat", pending[11], 32'(executeFormat));
            compareField("executeMemoryRead", pending[12], 32'(executeMemoryRead));
            compareField("executeMemoryWrite", pending[13], 32'(executeMemoryWrite));
            compareField("executeMemorySigned", pending[14], 32'(executeMemorySigned));
            compareField("executeMemoryWidth", pending[15], 32'(executeMemoryWidth));
            compareField("executeTrap", pending[16], 32'(executeTrap));
            compareField("executeFaultingAddress", pending[17],
                         32'(executeFaultingAddress));
            compareField("executeImmediate", pending[18], 32'(executeImmediate));
        end
    end

endmodule

// ==== tests/decodeStageTb.sv ====
`include "decodeSettings.svh"

module decodeStageTb;

    localparam int FIELDS = 25;
    localparam int MAX_LINES = 64;
    localparam int CHECK_FIELDS = 19;

    logic clock = 1'b0;
    logic reset;
    logic fetchValid;
    logic fetchAccessFault;
    logic stall;
    logic flush;
    decodePkg::instructionWord instruction;
    logic [`XLEN-1:0] programCounter;
    logic [`REG_ADDR_WIDTH-1:0] readAddress1;
    logic [`REG_ADDR_WIDTH-1:0] readAddress2;
    logic executeValid;
    logic [`XLEN-1:0] executeProgramCounter;
    logic [`REG_ADDR_WIDTH-1:0] executeDestinationRegister;
    logic [3:0] executeAluOperation;
    logic [1:0] executeAluSource;
    logic [1:0] executeWriteback;
    logic [2:0] executeBranch;
    logic [1:0] executeJump;
    logic [2:0] executeFormat;
    logic executeMemoryRead;
    logic executeMemoryWrite;
    logic executeMemorySigned;
    logic [1:0] executeMemoryWidth;
    logic [2:0] executeTrap;
    logic [`XLEN-1:0] executeFaultingAddress;
    logic [`XLEN-1:0] executeImmediate;

    logic [31:0] traceData [0:FIELDS*MAX_LINES-1];
    logic [31:0] expectedFields [CHECK_FIELDS];
    logic traceDone;
    int lineCount;
    int cycleCount = 0;
    int errorCount;

    always #4 clock = ~clock;

    decodeStage u_dut (.*);

    decodeChecker u_checker (.*);

    // Stimulus columns first, then read addresses, then registered outputs
    task automatic applyLine(input int line);
        int base;
        int k;
        base = line * FIELDS;
        fetchValid = traceData[base+1][0];
        fetchAccessFault = traceData[base+2][0];
        stall = traceData[base+3][0];
        flush = traceData[base+4][0];
        instruction = traceData[base+5];
        programCounter = traceData[base+6];
        expectedFields[0] = traceData[base];
        expectedFields[1] = traceData[base+7];
        expectedFields[2] = traceData[base+8];
        for (k = 3; k < CHECK_FIELDS; k++)
            expectedFields[k] = traceData[base+6+k];
    endtask

    always @(posedge clock) begin
        cycleCount++;
        if (lineCount != 0 && cycleCount >= lineCount + `TIMEOUT_MARGIN) begin
            $display("Run stopped because the cycle limit of %0d was reached", cycleCount);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        int index;
        reset = 1'b1;
        fetchValid = 1'b0;
        fetchAccessFault = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        instruction = '0;
        programCounter = '0;
        traceDone = 1'b0;
        lineCount = 0;
        for (index = 0; index < CHECK_FIELDS; index++)
            expectedFields[index] = '0;
        for (index = 0; index < FIELDS * MAX_LINES; index++)
            traceData[index] = ~index; // Unwritten words hold their inverted index
        $readmemh("tests/decodeTrace.txt", traceData);
        while (lineCount < MAX_LINES && traceData[lineCount*FIELDS] != ~(lineCount*FIELDS))
            lineCount++;
        for (index = 0; index < lineCount; index++) begin
            if (index != 0) begin
                @(posedge clock);
                #1;
            end
            applyLine(index);
            reset = (index < 2); // First two lines run under reset
        end
        @(posedge clock);
        #1;
        expectedFields[0] = '0;
        @(negedge clock);
        #1;
        traceDone = 1'b1;
        #1;
        if (lineCount == 0)
            $display("No lines were read from the trace file");
        if (errorCount == 0 && lineCount != 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== tests/decodeTrace.txt ====
// test fetchValid accessFault stall flush instruction pc readAddr1 readAddr2
// then valid pc rd aluOp aluSrc wb branch jump format memRd memWr signed width trap fault imm
1 1 0 0 0 002081B3 100 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 0 0 0 002081B3 100 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 1 0 0 0 002081B3 100 1 2 1 100 3 0 0 1 0 0 0 0 0 0 0 0 0 0
2 1 0 0 0 407302B3 104 6 7 1 104 5 1 0 1 0 0 0 0 0 0 0 0 0 0
2 1 0 0 0 40C5D533 108 B C 1 108 A 7 0 1 0 0 0 0 0 0 0 0 0 0
2 1 0 0 0 003130B3 10C 2 3 1 10C 1 9 0 1 0 0 0 0 0 0 0 0 0 0
2 1 0 0 0 FFF28213 110 5 0 1 110 4 0 1 1 0 0 1 0 0 0 0 0 0 FFFFFFFF
2 1 0 0 0 4033D313 114 7 0 1 114 6 7 1 1 0 0 1 0 0 0 0 0 0 403
2 1 0 0 0 02339313 118 7 0 1 118 0 5 1 0 0 0 0 0 0 0 0 1 02339313 0
3 1 0 0 0 FFC49403 200 9 0 1 200 8 0 1 2 0 0 1 1 0 1 1 0 0 FFFFFFFC
3 1 0 0 0 00514083 204 2 0 1 204 1 0 1 2 0 0 1 1 0 0 0 0 0 5
3 1 0 0 0 FE532C23 208 6 5 1 208 0 0 1 0 0 0 2 0 1 0 3 0 0 FFFFFFF8
3 1 0 0 0 00209863 20C 1 2 1 20C 0 0 2 0 2 0 3 0 0 0 0 0 0 10
3 1 0 0 0 FE41FCE3 210 3 4 1 210 0 0 2 0 6 0 3 0 0 0 0 0 0 FFFFFFF8
3 1 0 0 0 123453B7 214 0 0 1 214 7 0 3 1 0 0 4 0 0 0 0 0 0 12345000
3 1 0 0 0 FFFFF417 218 0 0 1 218 8 0 2 1 0 0 4 0 0 0 0 0 0 FFFFF000
3 1 0 0 0 001000EF 21C 0 0 1 21C 1 0 2 3 0 1 5 0 0 0 0 0 0 800
3 1 0 0 0 00C302E7 220 6 0 1 220 5 0 1 3 0 2 1 0 0 0 0 0 0 C
4 1 0 0 0 FFFFFFFF 300 0 0 1 300 0 0 0 0 0 0 0 0 0 0 0 1 FFFFFFFF 0
4 1 0 0 0 00013083 304 2 0 1 304 0 0 1 0 0 0 0 0 0 1 0 1 00013083 0
4 1 0 0 0 300110F3 308 2 0 1 308 0 0 0 0 0 0 0 0 0 0 0 1 300110F3 0
4 1 0 0 0 00000073 30C 0 0 1 30C 0 0 0 0 0 0 0 0 0 0 0 2 0 0
4 1 0 0 0 00100073 310 0 0 1 310 0 0 0 0 0 0 0 0 0 0 0 3 0 0
4 1 0 0 0 0FF0000F 314 0 0 1 314 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 1 0 0 0 10500073 318 0 0 1 318 0 0 0 0 0 0 0 0 0 0 0 0 0 0
5 1 1 0 0 FFF28213 400 5 0 1 400 0 0 1 0 0 0 1 0 0 0 0 4 400 FFFFFFFF
5 1 1 0 0 FFFFFFFF 404 0 0 1 404 0 0 0 0 0 0 0 0 0 0 0 4 404 0
6 1 0 0 0 002081B3 500 1 2 1 500 3 0 0 1 0 0 0 0 0 0 0 0 0 0
6 1 0 1 0 407302B3 504 6 7 1 500 3 0 0 1 0 0 0 0 0 0 0 0 0 0
6 1 0 1 1 407302B3 504 6 7 0 500 3 0 0 1 0 0 0 0 0 0 0 0 0 0
6 1 0 0 0 407302B3 504 6 7 1 504 5 1 0 1 0 0 0 0 0 0 0 0 0 0
6 0 0 0 0 FFC49403 508 9 0 0 508 8 0 1 2 0 0 1 1 0 1 1 0 0 FFFFFFFC
6 0 0 0 0 FFFFFFFF 50C 0 0 0 50C 0 0 0 0 0 0 0 0 0 0 0 1 FFFFFFFF 0
6 1 0 0 1 002081B3 510 1 2 0 50C 0 0 0 0 0 0 0 0 0 0 0 1 FFFFFFFF 0
6 1 0 0 0 002081B3 514 1 2 1 514 3 0 0 1 0 0 0 0 0 0 0 0 0 0

// ==== tb.f ====
+incdir+source
source/decodePkg.sv
source/instructionDecoder.sv
source/immediateGenerator.sv
source/decodeExecuteRegister.sv
source/decodeStage.sv
tests/decodeChecker.sv
tests/decodeStageTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= decodeStageTb
BUILD_DIR ?= obj_dir
FILE_LIST ?= tb.f
VERILATOR_FLAGS ?= --binary --timing --assert
PASS_TEXT ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check for a pass"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP BUILD_DIR FILE_LIST VERILATOR_FLAGS"

$(BUILD_DIR)/V$(TOP): $(FILE_LIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: $(BUILD_DIR)/V$(TOP)
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -Fqx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
